//--- filelist.f
rtl/win_pkg.sv
rtl/counter.sv
rtl/edge_ram.sv
rtl/axis_pixels.sv
rtl/row_accumulator.sv
rtl/sum_packer.sv
rtl/window_sum_engine.sv
tb/window_sum_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module window_sum_tb \
  -f filelist.f \
  --Mdir obj_dir -o window_sum_sim

./obj_dir/window_sum_sim

//--- tb/window_sum_tb.sv
`timescale 1ns/100ps

module window_sum_tb
  import win_pkg::*;
();

  typedef acc_t [ROWS-1:0] beat_t;

  // Taps per frame are input beats times 2*kh2+1
  localparam int TAP_CYCLES   = 12 + 216 + 60 + 64 + 72;
  // Input gaps, output stalls, reset and two idle tails
  localparam int STALL_CYCLES = 2 * 21 + 60 + 45;
  localparam int MAX_CYCLES   = 4 * (TAP_CYCLES + STALL_CYCLES);
  localparam int SETTLE_NS    = 1;

  logic                  aclk;
  logic                  aresetn;
  logic                  s_ready;
  logic                  s_valid;
  logic                  s_last;
  pixel_t [IN_WORDS-1:0] s_data;
  logic                  m_ready;
  logic                  m_valid;
  beat_t                 m_data;
  logic                  m_last;

  int    image [ROWS*IM_BLOCKS_MAX][IM_COLS_MAX][IM_CIN_MAX];
  int    n_rows;
  int    cfg_kh2;
  int    cfg_cin;
  int    cfg_cols;
  int    cfg_blocks;
  beat_t exp_beats [$];
  logic  exp_last [$];
  int    cycle_count;

  window_sum_engine dut0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_ready (s_ready),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last)
  );

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Simulation failed");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0t: %s got %0h, expected %0h", $time, name, got, expected);
      $display("Simulation failed");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  // Rows outside the image read as zero
  function automatic int pixel_at(input int row, input int col, input int ch);
    if (row < 0 || row >= n_rows) begin
      return 0;
    end
    return image[row][col][ch];
  endfunction

  task automatic prepare_frame(input int kh2, input int cin, input int cols, input int blocks);
    beat_t beat;
    int    sum;
    cfg_kh2    = kh2;
    cfg_cin    = cin;
    cfg_cols   = cols;
    cfg_blocks = blocks;
    n_rows     = blocks * ROWS;
    for (int r = 0; r < n_rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        for (int ch = 0; ch < cin; ch++) begin
          image[r][c][ch] = $urandom % 256;
        end
      end
    end
    // Vertical box sum over all channels, one beat per column
    for (int b = 0; b < blocks; b++) begin
      for (int c = 0; c < cols; c++) begin
        for (int lane = 0; lane < ROWS; lane++) begin
          sum = 0;
          for (int ch = 0; ch < cin; ch++) begin
            for (int dy = -kh2; dy <= kh2; dy++) begin
              sum += pixel_at(b * ROWS + lane + dy, c, ch);
            end
          end
          beat[lane] = acc_t'(sum);
        end
        exp_beats.push_back(beat);
        exp_last.push_back(b == blocks - 1 && c == cols - 1);
      end
    end
  endtask

  task automatic send_beat(input pixel_t [IN_WORDS-1:0] data, input logic last, input bit gaps);
    int idle;
    idle = gaps ? $urandom % 3 : 0;
    repeat (idle) begin
      @(negedge aclk);
      s_valid = 1'b0;
    end
    @(negedge aclk);
    s_valid = 1'b1;
    s_data  = data;
    s_last  = last;
    #(SETTLE_NS);
    while (!s_ready) begin
      @(negedge aclk);
      #(SETTLE_NS);
    end
    @(posedge aclk);
  endtask

  task automatic send_frame(input bit gaps);
    logic [IN_WORDS*WORD_WIDTH-1:0] word;
    logic                           last;
    word = '0;
    word[CFG_WIDTH-1:0] = {blocks_t'(cfg_blocks - 1), cols_t'(cfg_cols - 1),
                           cin_t'(cfg_cin - 1), kh2_t'(cfg_kh2)};
    send_beat(word, 1'b0, 1'b0);
    for (int b = 0; b < cfg_blocks; b++) begin
      for (int c = 0; c < cfg_cols; c++) begin
        for (int ch = 0; ch < cfg_cin; ch++) begin
          // Words past ROWS are the rows below the block
          for (int i = 0; i < IN_WORDS; i++) begin
            word[i*WORD_WIDTH +: WORD_WIDTH] = pixel_t'(pixel_at(b * ROWS + i, c, ch));
          end
          last = (b == cfg_blocks - 1) && (c == cfg_cols - 1) && (ch == cfg_cin - 1);
          send_beat(word, last, gaps);
        end
      end
    end
    @(negedge aclk);
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic collect_beats(input int count, input bit stalls);
    bit got;
    for (int n = 0; n < count; n++) begin
      got = 1'b0;
      while (!got) begin
        @(negedge aclk);
        m_ready = stalls ? ($urandom % 4 != 0) : 1'b1;
        #(SETTLE_NS);
        got = m_valid && m_ready;
      end
      check_value("m_data", m_data, exp_beats.pop_front());
      check_value("m_last", m_last, exp_last.pop_front());
    end
  endtask

  task automatic check_after_reset();
    @(negedge aclk);
    #(SETTLE_NS);
    check_value("s_ready", s_ready, 1'b1);
    check_value("m_valid", m_valid, 1'b0);
  endtask

  task automatic run_frame(input int kh2, input int cin, input int cols, input int blocks,
                           input bit gaps, input bit stalls);
    prepare_frame(kh2, cin, cols, blocks);
    fork
      send_frame(gaps);
      collect_beats(blocks * cols, stalls);
    join
  endtask

  // Second config goes in while the first frame still drains
  task automatic run_back_to_back();
    fork
      begin
        prepare_frame(0, 1, 16, 4);
        send_frame(1'b0);
        prepare_frame(1, 4, 3, 2);
        send_frame(1'b0);
      end
      collect_beats(4 * 16 + 2 * 3, 1'b0);
    join
  endtask

  // No beat beyond the expected ones, streamer back in CONFIG
  task automatic check_idle();
    m_ready = 1'b1;
    repeat (20) begin
      @(negedge aclk);
      #(SETTLE_NS);
      check_value("m_valid", m_valid, 1'b0);
    end
    check_value("s_ready", s_ready, 1'b1);
  endtask

  initial begin
    void'($urandom(60));
    cycle_count = 0;
    aresetn     = 1'b0;
    s_valid     = 1'b0;
    s_last      = 1'b0;
    s_data      = '0;
    m_ready     = 1'b0;
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    check_after_reset();
    run_frame(0, 2, 6, 1, 1'b0, 1'b0);
    run_frame(1, 3, 8, 3, 1'b0, 1'b0);
    run_frame(1, 2, 5, 2, 1'b1, 1'b1);
    check_idle();
    run_back_to_back();
    check_idle();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- rtl/window_sum_engine.sv
`timescale 1ns/100ps

module window_sum_engine
  import win_pkg::*;
(
  input  logic                   aclk,
  input  logic                   aresetn,

  output logic                   s_ready,
  input  logic                   s_valid,
  input  logic                   s_last,
  input  pixel_t [IN_WORDS-1:0]  s_data,

  input  logic                   m_ready,
  output logic                   m_valid,
  output acc_t [ROWS-1:0]        m_data,
  output logic                   m_last
);

  logic              tap_valid;
  pixel_t [ROWS-1:0] tap_data;
  logic              tap_col_end;
  logic              tap_frame_end;
  logic              pack_ready;

  logic [ROWS-1:0]   sum_valid;
  acc_t [ROWS-1:0]   sums;
  logic [ROWS-1:0]   sum_frame_end;

  axis_pixels pixels (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_ready       (s_ready),
    .s_valid       (s_valid),
    .s_last        (s_last),
    .s_data        (s_data),
    .tap_ready     (pack_ready),
    .tap_valid     (tap_valid),
    .tap_data      (tap_data),
    .tap_col_end   (tap_col_end),
    .tap_frame_end (tap_frame_end)
  );

  for (genvar r = 0; r < ROWS; r++) begin : g_lane
    row_accumulator acc (
      .aclk          (aclk),
      .aresetn       (aresetn),
      .tap_valid     (tap_valid),
      .tap_in        (tap_data[r]),
      .tap_col_end   (tap_col_end),
      .tap_frame_end (tap_frame_end),
      .sum_ready     (pack_ready),
      .sum_valid     (sum_valid[r]),
      .sum           (sums[r]),
      .sum_frame_end (sum_frame_end[r])
    );
  end

  // Lanes share one handshake, so lane 0 speaks for all
  sum_packer packer (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .in_valid     (sum_valid[0]),
    .in_sums      (sums),
    .in_frame_end (sum_frame_end[0]),
    .in_ready     (pack_ready),
    .m_ready      (m_ready),
    .m_valid      (m_valid),
    .m_data       (m_data),
    .m_last       (m_last)
  );

  assert property (@(posedge aclk) disable iff (!aresetn)
    sum_valid == {ROWS{sum_valid[0]}});

  assert property (@(posedge aclk) disable iff (!aresetn)
    sum_valid[0] |-> sum_frame_end == {ROWS{sum_frame_end[0]}});

endmodule

//--- rtl/sum_packer.sv
`timescale 1ns/100ps

module sum_packer
  import win_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,

  input  logic              in_valid,
  input  acc_t [ROWS-1:0]   in_sums,
  input  logic              in_frame_end,
  output logic              in_ready,

  input  logic              m_ready,
  output logic              m_valid,
  output acc_t [ROWS-1:0]   m_data,
  output logic              m_last
);

  logic in_fire;
  logic m_fire;

  assign m_fire   = m_valid && m_ready;
  assign in_ready = !m_valid || m_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid <= 1'b0;
    end else if (in_fire) begin
      m_valid <= 1'b1;
    end else if (m_fire) begin
      m_valid <= 1'b0;
    end
  end

  // Frame end flag follows the beat it belongs to
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_last <= 1'b0;
    end else if (in_fire) begin
      m_last <= in_frame_end;
    end else if (m_fire) begin
      m_last <= 1'b0;
    end
  end

  // Lane 0 lands in the low word
  always_ff @(posedge aclk) begin
    if (in_fire) begin
      m_data <= in_sums;
    end
  end

  assert property (@(posedge aclk) disable iff (!aresetn)
    m_last |-> m_valid);

endmodule

//--- rtl/row_accumulator.sv
`timescale 1ns/100ps

module row_accumulator
  import win_pkg::*;
(
  input  logic   aclk,
  input  logic   aresetn,

  input  logic   tap_valid,
  input  pixel_t tap_in,
  input  logic   tap_col_end,
  input  logic   tap_frame_end,

  input  logic   sum_ready,
  output logic   sum_valid,
  output acc_t   sum,
  output logic   sum_frame_end
);

  acc_t acc;
  acc_t acc_next;
  logic tap_fire;
  logic sum_fire;

  // Taps wait while a pending sum cannot leave
  assign tap_fire = tap_valid && sum_ready;
  assign sum_fire = sum_valid && sum_ready;
  assign acc_next = acc + acc_t'(tap_in);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      acc <= '0;
    end else if (tap_fire) begin
      if (tap_col_end) begin
        acc <= '0;
      end else begin
        acc <= acc_next;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      sum_valid <= 1'b0;
    end else if (tap_fire && tap_col_end) begin
      sum_valid <= 1'b1;
    end else if (sum_fire) begin
      sum_valid <= 1'b0;
    end
  end

  // Column total
  always_ff @(posedge aclk) begin
    if (tap_fire && tap_col_end) begin
      sum           <= acc_next;
      sum_frame_end <= tap_frame_end;
    end
  end

endmodule

//--- rtl/axis_pixels.sv
`timescale 1ns/100ps

module axis_pixels
  import win_pkg::*;
(
  input  logic                   aclk,
  input  logic                   aresetn,

  output logic                   s_ready,
  input  logic                   s_valid,
  input  logic                   s_last,
  input  pixel_t [IN_WORDS-1:0]  s_data,

  input  logic                   tap_ready,
  output logic                   tap_valid,
  output pixel_t [ROWS-1:0]      tap_data,
  output logic                   tap_col_end,
  output logic                   tap_frame_end
);

  stream_state_t state;

  logic en_config;
  logic pixel_fire;
  logic tap_fire;

  logic [IN_WORDS*WORD_WIDTH-1:0] s_flat;
  kh2_t    cfg_kh2;
  cin_t    cfg_cin;
  cols_t   cfg_cols;
  blocks_t cfg_blocks;
  kh2_t    kh2_r;

  logic [BITS_KH-1:0] taps_max;
  logic tap_last;
  logic ci_last, ci_wrap;
  logic col_wrap;
  logic blk_first, blk_last;

  ram_addr_t ram_addr;
  pixel_t [EDGE_WORDS-1:0] ram_rd_data;
  pixel_t [EDGE_WORDS-1:0] edge_top;

  // Stage after the RAM read
  logic                  r_valid;
  logic                  r_adv;
  pixel_t [IN_WORDS-1:0] data_r;
  logic                  first_blk_r;
  logic                  col_end_r;
  logic                  frame_end_r;

  // Tap stage
  logic                     sh_valid;
  logic                     sh_free;
  pixel_t [SHIFT_WORDS-1:0] shift_reg;
  logic                     sh_col_end;
  logic                     sh_frame_end;

  assign s_flat = s_data;
  assign {cfg_blocks, cfg_cols, cfg_cin, cfg_kh2} = s_flat[CFG_WIDTH-1:0];

  assign en_config  = (state == CONFIG);
  assign pixel_fire = (state == PASS) && s_valid && s_ready;
  assign tap_fire   = tap_valid && tap_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= CONFIG;
    end else begin
      case (state)
        CONFIG: if (s_valid) state <= PASS;
        PASS:   if (pixel_fire && s_last) state <= DRAIN;
        DRAIN:  if (tap_fire && tap_frame_end) state <= CONFIG;
        default: state <= CONFIG;
      endcase
    end
  end

  always_comb begin
    case (state)
      CONFIG:  s_ready = 1'b1;
      PASS:    s_ready = !r_valid || r_adv;
      default: s_ready = 1'b0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (en_config) begin
      kh2_r <= cfg_kh2;
    end
  end

  assign taps_max = BITS_KH'({cfg_kh2, 1'b0});

  // Taps run on the output side, the rest follows input beats
  counter #(.W(BITS_KH)) tap_cnt (
    .aclk(aclk), .clear(en_config), .en(tap_fire), .max_count(taps_max),
    .first(), .last(tap_last), .last_clk()
  );

  counter #(.W(BITS_CIN)) ci_cnt (
    .aclk(aclk), .clear(en_config), .en(pixel_fire), .max_count(cfg_cin),
    .first(), .last(ci_last), .last_clk(ci_wrap)
  );

  counter #(.W(BITS_COLS)) col_cnt (
    .aclk(aclk), .clear(en_config), .en(ci_wrap), .max_count(cfg_cols),
    .first(), .last(), .last_clk(col_wrap)
  );

  counter #(.W(BITS_BLOCKS)) blk_cnt (
    .aclk(aclk), .clear(en_config), .en(col_wrap), .max_count(cfg_blocks),
    .first(blk_first), .last(blk_last), .last_clk()
  );

  // One address per channel and column, restarting each block
  always_ff @(posedge aclk) begin
    if (en_config || col_wrap) begin
      ram_addr <= '0;
    end else if (pixel_fire) begin
      ram_addr <= ram_addr + 1'b1;
    end
  end

  edge_ram edge_mem (
    .aclk    (aclk),
    .rd_en   (pixel_fire && !blk_first),
    .rd_addr (ram_addr),
    .rd_data (ram_rd_data),
    .wr_en   (pixel_fire && !blk_last),
    .wr_addr (ram_addr),
    .wr_data (s_data[ROWS-1 -: EDGE_WORDS])
  );

  assign sh_free = !sh_valid || (tap_fire && tap_last);
  assign r_adv   = r_valid && sh_free;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      r_valid <= 1'b0;
    end else if (pixel_fire) begin
      r_valid <= 1'b1;
    end else if (r_adv) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (pixel_fire) begin
      data_r      <= s_data;
      first_blk_r <= blk_first;
      col_end_r   <= ci_last;
      frame_end_r <= s_last;
    end
  end

  // Zero padding above the first block
  assign edge_top = first_blk_r ? '0 : ram_rd_data;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      sh_valid <= 1'b0;
    end else if (r_adv) begin
      sh_valid <= 1'b1;
    end else if (tap_fire && tap_last) begin
      sh_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (r_adv) begin
      shift_reg    <= {data_r, edge_top};
      sh_col_end   <= col_end_r;
      sh_frame_end <= frame_end_r;
    end else if (tap_fire) begin
      shift_reg    <= shift_reg >> WORD_WIDTH;
    end
  end

  // Lane r starts kh2 rows above its own row
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      tap_data[r] = shift_reg[r + EDGE_WORDS - int'(kh2_r)];
    end
  end

  assign tap_valid     = sh_valid;
  assign tap_col_end   = sh_col_end && tap_last;
  assign tap_frame_end = sh_frame_end && tap_last;

  assert property (@(posedge aclk) disable iff (!aresetn)
    tap_valid && !tap_ready |=> tap_valid && $stable(tap_data));

endmodule

//--- rtl/edge_ram.sv
`timescale 1ns/100ps

module edge_ram
  import win_pkg::*;
(
  input  logic                     aclk,

  input  logic                     rd_en,
  input  ram_addr_t                rd_addr,
  output pixel_t [EDGE_WORDS-1:0]  rd_data,

  input  logic                     wr_en,
  input  ram_addr_t                wr_addr,
  input  pixel_t [EDGE_WORDS-1:0]  wr_data
);

  pixel_t [EDGE_WORDS-1:0] mem [RAM_DEPTH];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read returns the old word on an address collision
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- rtl/counter.sv
`timescale 1ns/100ps

module counter #(
  parameter int W = 4
) (
  input  logic         aclk,
  input  logic         clear,
  input  logic         en,
  input  logic [W-1:0] max_count,
  output logic         first,
  output logic         last,
  output logic         last_clk
);

  logic [W-1:0] count;
  logic [W-1:0] max_r;

  // Maximum is captured while clear is held
  always_ff @(posedge aclk) begin
    if (clear) begin
      count <= '0;
      max_r <= max_count;
    end else if (en) begin
      if (last) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign first    = (count == '0);
  assign last     = (count == max_r);

  // Wraps on this edge
  assign last_clk = last && en;

endmodule

//--- rtl/win_pkg.sv
package win_pkg;

  // Array geometry
  localparam int ROWS          = 4;
  localparam int KH_MAX        = 3;
  localparam int EDGE_WORDS    = KH_MAX / 2;
  localparam int WORD_WIDTH    = 8;

  // Largest image handled
  localparam int IM_CIN_MAX    = 4;
  localparam int IM_COLS_MAX   = 16;
  localparam int IM_BLOCKS_MAX = 4;

  // Derived sizes
  localparam int IN_WORDS      = ROWS + EDGE_WORDS;
  localparam int SHIFT_WORDS   = ROWS + KH_MAX - 1;
  localparam int RAM_DEPTH     = IM_CIN_MAX * IM_COLS_MAX;

  // Holds KH_MAX * IM_CIN_MAX * 255
  localparam int ACC_WIDTH     = 12;

  localparam int BITS_KH2      = $clog2((KH_MAX + 1) / 2);
  localparam int BITS_KH       = $clog2(KH_MAX);
  localparam int BITS_CIN      = $clog2(IM_CIN_MAX);
  localparam int BITS_COLS     = $clog2(IM_COLS_MAX);
  localparam int BITS_BLOCKS   = $clog2(IM_BLOCKS_MAX);
  localparam int BITS_RAM_ADDR = $clog2(RAM_DEPTH);

  // Config word: kh2, cin-1, cols-1, blocks-1 from the LSB
  localparam int CFG_WIDTH     = BITS_KH2 + BITS_CIN + BITS_COLS + BITS_BLOCKS;

  typedef logic [WORD_WIDTH-1:0]    pixel_t;
  typedef logic [ACC_WIDTH-1:0]     acc_t;
  typedef logic [BITS_KH2-1:0]      kh2_t;
  typedef logic [BITS_CIN-1:0]      cin_t;
  typedef logic [BITS_COLS-1:0]     cols_t;
  typedef logic [BITS_BLOCKS-1:0]   blocks_t;
  typedef logic [BITS_RAM_ADDR-1:0] ram_addr_t;

  typedef enum logic [1:0] {
    CONFIG,
    PASS,
    DRAIN
  } stream_state_t;

endpackage
